//--- hdl/cex_tracker.sv
module cex_tracker
	import cu_pkg::*;
(
	input  logic          clock,
	input  logic          cpucycle_rst,
	input  instr_fields_t fields,
	input  logic          cond_true,
	input  logic          decode_strobe,
	input  logic          exec_strobe,
	output logic          skip
);

	logic       active;		// A CEX block is still being counted down
	logic       result;		// Condition outcome latched at CEX execute
	logic [2:0] t_cnt;
	logic [2:0] f_cnt;
	logic       in_t;		// Current instruction counts against T

	assign in_t = (t_cnt != 3'd0);

	// True result runs the T group, false result runs the F group
	always_comb
	begin
		if (decode_strobe && active)
			skip = in_t ? !result : result;
		else
			skip = 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			active <= 1'b0;
			result <= 1'b0;
			t_cnt  <= 3'd0;
			f_cnt  <= 3'd0;
		end
		else if (exec_strobe && (fields.op == OP_CEX))
		begin
			active <= (fields.t_count != 3'd0) || (fields.f_count != 3'd0);	// Empty CEX does nothing
			result <= cond_true;
			t_cnt  <= fields.t_count;
			f_cnt  <= fields.f_count;
		end
		else if (decode_strobe && active)
		begin
			if (in_t)
			begin
				t_cnt <= t_cnt - 3'd1;
				if ((t_cnt == 3'd1) && (f_cnt == 3'd0))
					active <= 1'b0;			// Last counted instruction
			end
			else
			begin
				f_cnt <= f_cnt - 3'd1;
				if (f_cnt == 3'd1)
					active <= 1'b0;
			end
		end
	end

endmodule

//--- hdl/cond_eval.sv
module cond_eval
	import cu_pkg::*;
(
	input  instr_fields_t fields,
	input  psw_t          psw,
	output logic          cond_true
);

	logic [3:0] code;

	always_comb
	begin
		case (fields.op)
			OP_BEQ, OP_BNE, OP_BC, OP_BNC, OP_BN:
				code = 4'(fields.op - OP_BEQ);		// EQ to MI in order
			OP_BGE: code = 4'd10;
			OP_BLT: code = 4'd11;
			OP_BRA: code = 4'd14;				// Always
			OP_CEX: code = fields.cond;
			default: code = 4'd15;				// Never true
		endcase
	end

	always_comb
	begin
		case (code)
			4'd0:  cond_true = psw.z;					// EQ
			4'd1:  cond_true = !psw.z;					// NE
			4'd2:  cond_true = psw.c;					// CS
			4'd3:  cond_true = !psw.c;					// CC
			4'd4:  cond_true = psw.n;					// MI
			4'd5:  cond_true = !psw.n;					// PL
			4'd6:  cond_true = psw.v;					// VS
			4'd7:  cond_true = !psw.v;					// VC
			4'd8:  cond_true = psw.c && !psw.z;			// HI
			4'd9:  cond_true = !psw.c || psw.z;			// LS
			4'd10: cond_true = (psw.n == psw.v);		// GE
			4'd11: cond_true = (psw.n != psw.v);		// LT
			4'd12: cond_true = !psw.z && (psw.n == psw.v);	// GT
			4'd13: cond_true = psw.z || (psw.n != psw.v);	// LE
			4'd14: cond_true = 1'b1;					// AL
			default: cond_true = 1'b0;
		endcase
	end

endmodule

//--- hdl/control_unit.sv
module control_unit
	import cu_pkg::*;
#(
	parameter logic [15:0] PSW_INIT = 16'h60e0
)
(
	input  logic          clock,
	input  logic          cpucycle_rst,
	input  logic [15:0]   pc,
	input  logic [15:0]   brkpnt,
	input  instr_fields_t fields,
	input  flags_t        flags_in,
	input  logic          flags_load,
	output ctrl_word_t    ctrl,
	output logic          id_en,
	output step_e         step,
	output psw_t          psw,
	output logic          halted,
	output logic          fault,
	output logic [3:0]    vect_num
);

	logic fetch_strobe;
	logic decode_strobe;
	logic exec_strobe;
	logic skip;			// CEX drops the decoded instruction
	logic cond_true;
	logic pri_fault;

	step_sequencer u_seq (
		.clock         (clock),
		.cpucycle_rst  (cpucycle_rst),
		.pc            (pc),
		.brkpnt        (brkpnt),
		.skip          (skip),
		.pri_fault     (pri_fault),
		.step          (step),
		.fetch_strobe  (fetch_strobe),
		.decode_strobe (decode_strobe),
		.exec_strobe   (exec_strobe),
		.id_en         (id_en),
		.halted        (halted),
		.fault         (fault),
		.vect_num      (vect_num)
	);

	cond_eval u_cond (
		.fields    (fields),
		.psw       (psw),
		.cond_true (cond_true)
	);

	cex_tracker u_cex (
		.clock         (clock),
		.cpucycle_rst  (cpucycle_rst),
		.fields        (fields),
		.cond_true     (cond_true),
		.decode_strobe (decode_strobe),
		.exec_strobe   (exec_strobe),
		.skip          (skip)
	);

	psw_unit #(
		.PSW_INIT (PSW_INIT)
	) u_psw (
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.fields       (fields),
		.exec_strobe  (exec_strobe),
		.flags_in     (flags_in),
		.flags_load   (flags_load),
		.psw          (psw),
		.pri_fault    (pri_fault)
	);

	ctrl_word_gen u_cwg (
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.step         (step),
		.fetch_strobe (fetch_strobe),
		.exec_strobe  (exec_strobe),
		.fields       (fields),
		.cond_true    (cond_true),
		.ctrl         (ctrl)
	);

endmodule

//--- hdl/ctrl_word_gen.sv
module ctrl_word_gen
	import cu_pkg::*;
(
	input  logic          clock,
	input  logic          cpucycle_rst,
	input  step_e         step,
	input  logic          fetch_strobe,
	input  logic          exec_strobe,
	input  instr_fields_t fields,
	input  logic          cond_true,
	output ctrl_word_t    ctrl
);

	ctrl_word_t exec_word;
	ctrl_word_t next_word;
	logic [4:0] rd;		// Instruction dst as register number

	assign rd = {2'b00, fields.dst};

	always_comb
	begin
		exec_word       = '0;
		exec_word.valid = 1'b1;
		case (fields.op)
			OP_BEQ, OP_BNE, OP_BC, OP_BNC, OP_BN, OP_BGE, OP_BLT, OP_BRA:
			begin
				exec_word.valid         = cond_true;	// Not taken gives no word
				exec_word.sxt_bit_num   = 5'd10;
				exec_word.sxt_shift     = 1'b1;		// Word offset to byte offset
				exec_word.sxt_from_off  = 1'b1;
				exec_word.s_from_sxt    = 1'b1;
				exec_word.alu_op        = 6'd0;		// PC + offset
				exec_word.alu_rnum_dst  = REG_PC;
				exec_word.data_src      = SRC_ALU;
				exec_word.data_dst      = DST_REGF;
				exec_word.dbus_rnum_dst = REG_PC;
			end
			OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_DADD, OP_CMP,
			OP_XOR, OP_AND, OP_OR, OP_BIT, OP_BIC, OP_BIS:
			begin
				exec_word.alu_op        = {5'(fields.op - OP_ADD), fields.word_byte};
				exec_word.alu_rnum_dst  = rd;
				exec_word.alu_rnum_src  = {1'b0, fields.reg_const, fields.src};	// Constants sit at 8 to 15
				exec_word.psw_update    = 1'b1;
				exec_word.word_byte     = fields.word_byte;
				exec_word.data_src      = SRC_ALU;
				exec_word.data_dst      = DST_REGF;
				exec_word.dbus_rnum_dst = rd;
			end
			OP_MOV:
			begin
				exec_word.word_byte     = fields.word_byte;
				exec_word.data_src      = SRC_REGF;
				exec_word.data_dst      = DST_REGF;
				exec_word.dbus_rnum_src = {2'b00, fields.src};
				exec_word.dbus_rnum_dst = rd;
			end
			OP_SWPB, OP_MOVL, OP_MOVLZ, OP_MOVLS, OP_MOVH:
			begin
				exec_word.bm_op         = (fields.op == OP_SWPB) ? 3'd4 : 3'(fields.op - OP_MOVL);
				exec_word.data_src      = SRC_BM;
				exec_word.data_dst      = DST_REGF;
				exec_word.dbus_rnum_dst = rd;
			end
			OP_SXT:
			begin
				exec_word.sxt_bit_num   = 5'd7;		// Byte sign bit, register input
				exec_word.data_src      = SRC_SXT;
				exec_word.data_dst      = DST_REGF;
				exec_word.dbus_rnum_dst = rd;
			end
			default: exec_word.valid = 1'b0;		// PSW ops, CEX and the rest
		endcase
	end

	always_comb
	begin
		next_word = '0;
		case (step)
			FETCH:
			begin
				next_word.valid        = fetch_strobe;	// No word while halted or faulted
				next_word.mar_from_pc  = 1'b1;
				next_word.mem_read     = 1'b1;
				next_word.alu_rnum_dst = REG_PC;
				next_word.alu_rnum_src = REG_CONST_TWO;
			end
			PC_INC:
			begin
				next_word.valid         = 1'b1;
				next_word.alu_rnum_dst  = REG_PC;	// ALU still forms PC + 2
				next_word.alu_rnum_src  = REG_CONST_TWO;
				next_word.data_src      = SRC_ALU;
				next_word.data_dst      = DST_REGF;
				next_word.dbus_rnum_dst = REG_PC;
			end
			IR_LOAD:
			begin
				next_word.valid    = 1'b1;
				next_word.data_src = SRC_MDR;
				next_word.data_dst = DST_IR;
			end
			EXECUTE:
				if (exec_strobe)
					next_word = exec_word;
			default: next_word.valid = 1'b0;		// Decode cycle drives nothing
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			ctrl <= '0;
		else
			ctrl <= next_word;
	end

endmodule

//--- hdl/cu_pkg.sv
package cu_pkg;

	typedef enum logic [6:0] {
		OP_BEQ    = 7'd1,		// Branch group, condition picked from opcode
		OP_BNE    = 7'd2,
		OP_BC     = 7'd3,
		OP_BNC    = 7'd4,
		OP_BN     = 7'd5,
		OP_BGE    = 7'd6,
		OP_BLT    = 7'd7,
		OP_BRA    = 7'd8,
		OP_ADD    = 7'd9,		// Register ALU group starts here
		OP_ADDC   = 7'd10,
		OP_SUB    = 7'd11,
		OP_SUBC   = 7'd12,
		OP_DADD   = 7'd13,
		OP_CMP    = 7'd14,
		OP_XOR    = 7'd15,
		OP_AND    = 7'd16,
		OP_OR     = 7'd17,
		OP_BIT    = 7'd18,
		OP_BIC    = 7'd19,
		OP_BIS    = 7'd20,		// Last ALU op
		OP_MOV    = 7'd21,
		OP_SWPB   = 7'd26,
		OP_SXT    = 7'd27,
		OP_SETPRI = 7'd28,
		OP_SETCC  = 7'd30,
		OP_CLRCC  = 7'd31,
		OP_CEX    = 7'd32,
		OP_MOVL   = 7'd35,		// Byte moves map onto bm_op 0 to 3
		OP_MOVLZ  = 7'd36,
		OP_MOVLS  = 7'd37,
		OP_MOVH   = 7'd38
	} opcode_e;

	typedef enum logic [2:0] {
		SRC_NONE = 3'd0,
		SRC_MDR  = 3'd1,
		SRC_REGF = 3'd2,
		SRC_ALU  = 3'd3,
		SRC_SXT  = 3'd4,
		SRC_BM   = 3'd5
	} bus_src_e;

	typedef enum logic [1:0] {
		DST_NONE = 2'd0,
		DST_MDR  = 2'd1,
		DST_REGF = 2'd2,
		DST_IR   = 2'd3
	} bus_dst_e;

	typedef enum logic [2:0] {
		FETCH   = 3'd1,
		PC_INC  = 3'd2,
		IR_LOAD = 3'd3,
		DECODE  = 3'd4,
		EXECUTE = 3'd5
	} step_e;

	typedef struct packed {
		opcode_e     op;
		logic [12:0] off;		// Branch offset, sign bit 10 for conditional branches
		logic [3:0]  cond;		// CEX condition code
		logic [2:0]  t_count;
		logic [2:0]  f_count;
		logic [2:0]  pri;
		logic [4:0]  pswb;		// v, slp, n, z, c select
		logic [2:0]  dst;
		logic [2:0]  src;
		logic        word_byte;	// 1 = byte
		logic        reg_const;	// 1 = src names a constant
	} instr_fields_t;

	typedef struct packed {
		logic        valid;
		bus_src_e    data_src;
		bus_dst_e    data_dst;
		logic        word_byte;
		logic [4:0]  dbus_rnum_dst;
		logic [4:0]  dbus_rnum_src;
		logic        mar_from_pc;
		logic        mar_from_alu;
		logic        mem_read;
		logic [5:0]  alu_op;
		logic [4:0]  alu_rnum_dst;
		logic [4:0]  alu_rnum_src;
		logic        s_from_sxt;	// ALU s-operand from sign extender
		logic        psw_update;
		logic [4:0]  sxt_bit_num;
		logic        sxt_shift;
		logic        sxt_from_off;	// Extend the offset, not a register
		logic [2:0]  bm_op;
	} ctrl_word_t;

	typedef struct packed {
		logic [7:0] upper;
		logic [2:0] pri;
		logic       v;
		logic       slp;
		logic       n;
		logic       z;
		logic       c;
	} psw_t;

	typedef struct packed {
		logic v;
		logic n;
		logic z;
		logic c;
	} flags_t;

	localparam logic [4:0] REG_PC        = 5'd7;
	localparam logic [4:0] REG_CONST_TWO = 5'd10;	// Register file slot holding constant 2
	localparam logic [3:0] VEC_PC_FAULT  = 4'd9;
	localparam logic [3:0] VEC_PRI_FAULT = 4'd10;

endpackage

//--- hdl/psw_unit.sv
module psw_unit
	import cu_pkg::*;
#(
	parameter logic [15:0] PSW_INIT = 16'h60e0
)
(
	input  logic          clock,
	input  logic          cpucycle_rst,
	input  instr_fields_t fields,
	input  logic          exec_strobe,
	input  flags_t        flags_in,
	input  logic          flags_load,
	output psw_t          psw,
	output logic          pri_fault
);

	logic is_setcc;
	logic is_clrcc;
	logic is_setpri;
	logic pri_ok;		// New priority is strictly lower

	assign is_setcc  = exec_strobe && (fields.op == OP_SETCC);
	assign is_clrcc  = exec_strobe && (fields.op == OP_CLRCC);
	assign is_setpri = exec_strobe && (fields.op == OP_SETPRI);
	assign pri_ok    = (fields.pri < psw.pri);
	assign pri_fault = is_setpri && !pri_ok;		// Raising priority is not allowed

	// Execute-step writes take precedence over ALU write-back flags
	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			psw <= psw_t'(PSW_INIT);
		else if (is_setcc)
			psw[4:0] <= psw[4:0] | fields.pswb;
		else if (is_clrcc)
			psw[4:0] <= psw[4:0] & ~fields.pswb;
		else if (is_setpri && pri_ok)
			psw.pri <= fields.pri;
		else if (flags_load)
		begin
			psw.c <= flags_in.c;
			psw.z <= flags_in.z;
			psw.n <= flags_in.n;
			psw.v <= flags_in.v;			// slp and pri untouched
		end
	end

endmodule

//--- hdl/step_sequencer.sv
module step_sequencer
	import cu_pkg::*;
(
	input  logic        clock,
	input  logic        cpucycle_rst,
	input  logic [15:0] pc,
	input  logic [15:0] brkpnt,
	input  logic        skip,
	input  logic        pri_fault,
	output step_e       step,
	output logic        fetch_strobe,
	output logic        decode_strobe,
	output logic        exec_strobe,
	output logic        id_en,
	output logic        halted,
	output logic        fault,
	output logic [3:0]  vect_num
);

	logic brk_hit;
	logic stalled;		// Halted or faulted, no strobes go out

	assign brk_hit = (pc == brkpnt);
	assign stalled = halted || fault;

	assign fetch_strobe  = (step == FETCH) && !stalled && !pc[0] && !brk_hit;
	assign decode_strobe = (step == DECODE) && !stalled;
	assign exec_strobe   = (step == EXECUTE) && !stalled;

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			step     <= FETCH;
			id_en    <= 1'b0;
			halted   <= 1'b0;
			fault    <= 1'b0;
			vect_num <= 4'd0;
		end
		else
		begin
			id_en <= decode_strobe && !skip;		// Decoder runs alongside EXECUTE
			case (step)
				FETCH:
				begin
					if (!fault)
					begin
						if (pc[0])
						begin
							fault    <= 1'b1;		// Odd PC
							vect_num <= VEC_PC_FAULT;
							halted   <= 1'b0;
						end
						else if (brk_hit)
							halted <= 1'b1;
						else if (halted)
							halted <= 1'b0;		// Release, fetch next cycle
						else
							step <= PC_INC;
					end
				end
				PC_INC:  step <= IR_LOAD;
				IR_LOAD: step <= DECODE;
				DECODE:  step <= skip ? FETCH : EXECUTE;	// Skipped instruction ends here
				EXECUTE: step <= FETCH;
				default: step <= FETCH;
			endcase
			if (pri_fault)
			begin
				fault    <= 1'b1;
				vect_num <= VEC_PRI_FAULT;
			end
		end
	end

endmodule

//--- project.f
hdl/cu_pkg.sv
hdl/cond_eval.sv
hdl/cex_tracker.sv
hdl/psw_unit.sv
hdl/step_sequencer.sv
hdl/ctrl_word_gen.sv
hdl/control_unit.sv
verification/control_unit_chk.sv
verification/tb_clock_gen.sv
verification/tb_control_unit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_control_unit -f project.f -o sim_control_unit

./obj_dir/sim_control_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
	exit 0
fi
exit 1

//--- verification/control_unit_chk.sv
module control_unit_chk
	import cu_pkg::*;
(
	input logic       clock,
	input logic       cpucycle_rst,
	input step_e      step,
	input logic       id_en,
	input ctrl_word_t ctrl,
	input logic       halted,
	input logic       fault
);

	// Decoder enable only lines up with the execute step
	property id_en_in_execute;
		@(posedge clock) disable iff (cpucycle_rst)
		id_en |-> (step == EXECUTE);
	endproperty

	property no_word_while_halted;
		@(posedge clock) disable iff (cpucycle_rst)
		halted |-> !ctrl.valid;
	endproperty

	property fault_is_sticky;		// Only reset clears a fault
		@(posedge clock) disable iff (cpucycle_rst)
		fault |=> fault;
	endproperty

	a_id_en: assert property (id_en_in_execute) else $error("id_en high outside EXECUTE");
	a_halt:  assert property (no_word_while_halted) else $error("Valid control word while halted");
	a_fault: assert property (fault_is_sticky) else $error("Fault dropped without reset");

endmodule

bind control_unit control_unit_chk u_chk (.*);

//--- verification/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD     = 100,
	parameter int RST_CYCLES = 16
)
(
	output logic clock,
	output logic rst
);

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;		// Free running
	end

	initial
	begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;		// Released away from the active edge
	end

endmodule

//--- verification/tb_control_unit.sv
module tb_control_unit
	import cu_pkg::*;
;

	localparam logic [15:0] PSW_INIT = 16'h60e0;

	logic          clock;
	logic          rst_init;		// Power-on reset from the clock module
	logic          rst_req;			// Extra reset pulses from the stimulus
	logic          cpucycle_rst;
	logic [15:0]   pc;
	logic [15:0]   brkpnt;
	instr_fields_t fields;
	flags_t        flags_in;
	logic          flags_load;
	ctrl_word_t    ctrl;
	logic          id_en;
	step_e         step;
	psw_t          psw;
	logic          halted;
	logic          fault;
	logic [3:0]    vect_num;

	logic          s_rst = 1'b1;		// Inputs as seen by the DUT at the last edge
	logic [15:0]   s_pc;
	logic [15:0]   s_brk;
	instr_fields_t s_fields;
	flags_t        s_flags;
	logic          s_fl;

	step_e         m_step;			// Reference model state
	ctrl_word_t    m_ctrl;
	logic          m_id_en;
	logic          m_halted;
	logic          m_fault;
	logic [3:0]    m_vect;
	psw_t          m_psw;
	logic          c_active;
	logic          c_res;
	logic [2:0]    c_t;
	logic [2:0]    c_f;

	logic [15:0]   lfsr;
	int            errors;
	int            checks;
	int            timeouts;
	string         test_name;
	opcode_e       single_ops [19];

	assign cpucycle_rst = rst_init | rst_req;

	tb_clock_gen #(
		.PERIOD     (100),
		.RST_CYCLES (16)
	) u_clk (
		.clock (clock),
		.rst   (rst_init)
	);

	control_unit #(
		.PSW_INIT (PSW_INIT)
	) dut (
		.clock        (clock),
		.cpucycle_rst (cpucycle_rst),
		.pc           (pc),
		.brkpnt       (brkpnt),
		.fields       (fields),
		.flags_in     (flags_in),
		.flags_load   (flags_load),
		.ctrl         (ctrl),
		.id_en        (id_en),
		.step         (step),
		.psw          (psw),
		.halted       (halted),
		.fault        (fault),
		.vect_num     (vect_num)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] out;
		out = '0;
		for (int i = 0; i < n; i++)
		begin
			out  = {out[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return out;
	endfunction

	function automatic instr_fields_t rand_fields(input opcode_e op);
		instr_fields_t f;
		f.op        = op;
		f.off       = 13'(take_bits(13));
		f.cond      = 4'(take_bits(4));
		f.t_count   = 3'(take_bits(3));
		f.f_count   = 3'(take_bits(3));
		f.pri       = 3'(take_bits(3));
		f.pswb      = 5'(take_bits(5));
		f.dst       = 3'(take_bits(3));
		f.src       = 3'(take_bits(3));
		f.word_byte = take_bits(1) != 0;
		f.reg_const = take_bits(1) != 0;
		return f;
	endfunction

	function automatic logic [3:0] cond_code(input instr_fields_t f);
		if ((f.op >= OP_BEQ) && (f.op <= OP_BN))
			return 4'(f.op - 7'd1);
		if (f.op == OP_BGE)
			return 4'd10;
		if (f.op == OP_BLT)
			return 4'd11;
		if (f.op == OP_BRA)
			return 4'd14;
		if (f.op == OP_CEX)
			return f.cond;
		return 4'd15;
	endfunction

	function automatic logic cond_holds(input logic [3:0] code, input psw_t p);
		case (code)
			4'd0:  return p.z;
			4'd1:  return !p.z;
			4'd2:  return p.c;
			4'd3:  return !p.c;
			4'd4:  return p.n;
			4'd5:  return !p.n;
			4'd6:  return p.v;
			4'd7:  return !p.v;
			4'd8:  return p.c && !p.z;
			4'd9:  return !p.c || p.z;
			4'd10: return p.n == p.v;
			4'd11: return p.n != p.v;
			4'd12: return !p.z && (p.n == p.v);
			4'd13: return p.z || (p.n != p.v);
			4'd14: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Expected registered word for one step of one instruction
	function automatic ctrl_word_t ref_word(input step_e st, input instr_fields_t f,
		input psw_t p, input logic fetch_ok, input logic exe);
		ctrl_word_t w;
		w = '0;
		if (st == FETCH)
		begin
			w.valid        = fetch_ok;
			w.mar_from_pc  = 1'b1;
			w.mem_read     = 1'b1;
			w.alu_rnum_dst = REG_PC;
			w.alu_rnum_src = REG_CONST_TWO;		// PC + 2
		end
		else if (st == PC_INC)
		begin
			w.valid         = 1'b1;
			w.alu_rnum_dst  = REG_PC;
			w.alu_rnum_src  = REG_CONST_TWO;
			w.data_src      = SRC_ALU;
			w.data_dst      = DST_REGF;
			w.dbus_rnum_dst = REG_PC;
		end
		else if (st == IR_LOAD)
		begin
			w.valid    = 1'b1;
			w.data_src = SRC_MDR;
			w.data_dst = DST_IR;
		end
		else if ((st == EXECUTE) && exe)
		begin
			w.dbus_rnum_dst = {2'b00, f.dst};		// Most words write dst
			w.data_dst      = DST_REGF;
			w.valid         = 1'b1;
			if ((f.op >= OP_BEQ) && (f.op <= OP_BRA))
			begin
				w.valid         = cond_holds(cond_code(f), p);
				w.sxt_bit_num   = 5'd10;
				w.sxt_shift     = 1'b1;
				w.sxt_from_off  = 1'b1;
				w.s_from_sxt    = 1'b1;
				w.alu_rnum_dst  = REG_PC;
				w.data_src      = SRC_ALU;
				w.dbus_rnum_dst = REG_PC;
			end
			else if ((f.op >= OP_ADD) && (f.op <= OP_BIS))
			begin
				w.alu_op       = 6'(2 * (f.op - 7'd9)) + 6'(f.word_byte);
				w.alu_rnum_dst = {2'b00, f.dst};
				w.alu_rnum_src = 5'(f.src) + (f.reg_const ? 5'd8 : 5'd0);
				w.psw_update   = 1'b1;
				w.word_byte    = f.word_byte;
				w.data_src     = SRC_ALU;
			end
			else if (f.op == OP_MOV)
			begin
				w.word_byte     = f.word_byte;
				w.data_src      = SRC_REGF;
				w.dbus_rnum_src = {2'b00, f.src};
			end
			else if (f.op == OP_SWPB)
			begin
				w.bm_op    = 3'd4;
				w.data_src = SRC_BM;
			end
			else if ((f.op >= OP_MOVL) && (f.op <= OP_MOVH))
			begin
				w.bm_op    = 3'(f.op - 7'd35);
				w.data_src = SRC_BM;
			end
			else if (f.op == OP_SXT)
			begin
				w.sxt_bit_num = 5'd7;
				w.data_src    = SRC_SXT;
			end
			else
				w = '0;		// No datapath action
		end
		return w;
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("[ERROR] %s %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	always @(posedge clock)
	begin
		s_rst    <= cpucycle_rst;
		s_pc     <= pc;
		s_brk    <= brkpnt;
		s_fields <= fields;
		s_flags  <= flags_in;
		s_fl     <= flags_load;
	end

	// Steps the model over the last edge and compares every output
	always @(negedge clock)
	begin : compare
		logic  stalled;
		logic  dec;
		logic  exe;
		logic  skp;
		logic  pf;
		logic  fetch_ok;
		step_e ns;
		psw_t  np;
		if (s_rst)
		begin
			m_step   = FETCH;
			m_ctrl   = '0;
			m_id_en  = 1'b0;
			m_halted = 1'b0;
			m_fault  = 1'b0;
			m_vect   = 4'd0;
			m_psw    = psw_t'(PSW_INIT);
			c_active = 1'b0;
			c_res    = 1'b0;
			c_t      = 3'd0;
			c_f      = 3'd0;
		end
		else
		begin
			stalled  = m_halted || m_fault;
			dec      = (m_step == DECODE) && !stalled;
			exe      = (m_step == EXECUTE) && !stalled;
			skp      = dec && c_active && ((c_t != 3'd0) ? !c_res : c_res);
			fetch_ok = (m_step == FETCH) && !stalled && !s_pc[0] && (s_pc != s_brk);
			m_ctrl   = ref_word(m_step, s_fields, m_psw, fetch_ok, exe);
			pf       = exe && (s_fields.op == OP_SETPRI) && !(s_fields.pri < m_psw.pri);
			m_id_en  = dec && !skp;
			if (exe && (s_fields.op == OP_CEX))
			begin
				c_res    = cond_holds(cond_code(s_fields), m_psw);
				c_t      = s_fields.t_count;
				c_f      = s_fields.f_count;
				c_active = (c_t != 3'd0) || (c_f != 3'd0);
			end
			else if (dec && c_active)
			begin
				if (c_t != 3'd0)
					c_t = c_t - 3'd1;		// T group is used up first
				else
					c_f = c_f - 3'd1;
				c_active = (c_t != 3'd0) || (c_f != 3'd0);
			end
			np = m_psw;
			if (exe && (s_fields.op == OP_SETCC))
				np[4:0] = np[4:0] | s_fields.pswb;
			else if (exe && (s_fields.op == OP_CLRCC))
				np[4:0] = np[4:0] & ~s_fields.pswb;
			else if (exe && (s_fields.op == OP_SETPRI) && !pf)
				np.pri = s_fields.pri;
			else if (s_fl)
			begin
				np.c = s_flags.c;
				np.z = s_flags.z;
				np.n = s_flags.n;
				np.v = s_flags.v;
			end
			ns = m_step;
			case (m_step)
				FETCH:
					if (!m_fault)
					begin
						if (s_pc[0])
						begin
							m_fault  = 1'b1;
							m_vect   = VEC_PC_FAULT;
							m_halted = 1'b0;
						end
						else if (s_pc == s_brk)
							m_halted = 1'b1;
						else if (m_halted)
							m_halted = 1'b0;		// One idle FETCH after release
						else
							ns = PC_INC;
					end
				PC_INC:  ns = IR_LOAD;
				IR_LOAD: ns = DECODE;
				DECODE:  ns = skp ? FETCH : EXECUTE;
				default: ns = FETCH;
			endcase
			if (pf)
			begin
				m_fault = 1'b1;
				m_vect  = VEC_PRI_FAULT;
			end
			m_step = ns;
			m_psw  = np;
			if (m_ctrl.valid)
				check_value("ctrl", 64'(m_ctrl), 64'(ctrl));
			else
				check_value("ctrl.valid", 64'(1'b0), 64'(ctrl.valid));
			check_value("id_en", 64'(m_id_en), 64'(id_en));
			check_value("step", 64'(m_step), 64'(step));
			check_value("psw", 64'(m_psw), 64'(psw));
			check_value("halted", 64'(m_halted), 64'(halted));
			check_value("fault", 64'(m_fault), 64'(fault));
			check_value("vect_num", 64'(m_vect), 64'(vect_num));
		end
	end

	task automatic wait_step(input step_e target, input logic equal, input string what);
		int n;
		n = 0;
		while (((step == target) != equal) && (n < 40))
		begin
			@(negedge clock);
			n++;
		end
		if ((step == target) != equal)
		begin
			timeouts++;
			$display("Timeout in %s while waiting for %s", test_name, what);
		end
	endtask

	task automatic wait_status(input logic use_fault, input logic level, input string what);
		int n;
		n = 0;
		while (((use_fault ? fault : halted) != level) && (n < 40))
		begin
			@(negedge clock);
			n++;
		end
		if ((use_fault ? fault : halted) != level)
		begin
			timeouts++;
			$display("Timeout in %s while waiting for %s", test_name, what);
		end
	endtask

	task automatic run_instr(input instr_fields_t f);
		wait_step(FETCH, 1'b1, "FETCH before issue");
		fields = f;
		pc     = {15'(take_bits(15)), 1'b0};		// Even and never equal to brkpnt
		wait_step(FETCH, 1'b0, "leaving FETCH");
		wait_step(FETCH, 1'b1, "end of instruction");
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic apply_reset();
		@(negedge clock);
		rst_req = 1'b1;
		idle(16);
		rst_req = 1'b0;
		idle(1);
	endtask

	initial
	begin
		instr_fields_t f;
		int            t;
		int            n;
		pc          = 16'h0000;
		brkpnt      = 16'hffff;
		fields      = '0;
		flags_in    = '0;
		flags_load  = 1'b0;
		rst_req     = 1'b0;
		lfsr        = 16'd19103;
		errors      = 0;
		checks      = 0;
		timeouts    = 0;
		single_ops  = '{OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_DADD, OP_CMP, OP_XOR, OP_AND,
			OP_OR, OP_BIT, OP_BIC, OP_BIS, OP_MOV, OP_SWPB, OP_SXT, OP_MOVL, OP_MOVLZ,
			OP_MOVLS, OP_MOVH};
		test_name   = "reset";
		@(negedge clock);		// DUT has taken a reset edge by now
		check_value("psw after reset", 64'(PSW_INIT), 64'(psw));
		check_value("step after reset", 64'(FETCH), 64'(step));
		check_value("ctrl.valid after reset", 64'(1'b0), 64'(ctrl.valid));
		check_value("id_en after reset", 64'(1'b0), 64'(id_en));
		check_value("halted after reset", 64'(1'b0), 64'(halted));
		check_value("fault after reset", 64'(1'b0), 64'(fault));
		check_value("vect_num after reset", 64'(4'd0), 64'(vect_num));
		n = 0;
		while (cpucycle_rst && (n < 40))
		begin
			@(posedge clock);
			n++;
		end
		if (cpucycle_rst)
		begin
			timeouts++;
			$display("Timeout in %s while waiting for reset release", test_name);
		end
		@(negedge clock);
		test_name = "fetch";
		repeat (3) run_instr(rand_fields(OP_MOV));
		test_name = "single_step";
		repeat (40) run_instr(rand_fields(single_ops[take_bits(5) % 19]));
		test_name = "conditions";
		repeat (4)
		begin
			run_instr(rand_fields(OP_SETCC));
			run_instr(rand_fields(OP_CLRCC));
			for (int k = 1; k <= 8; k++)
				run_instr(rand_fields(opcode_e'(k)));
			flags_in   = flags_t'(take_bits(4));		// ALU write-back between instructions
			flags_load = 1'b1;
			@(negedge clock);
			flags_load = 1'b0;
			for (int k = 1; k <= 8; k++)
				run_instr(rand_fields(opcode_e'(k)));
		end
		test_name = "cex";
		repeat (6)
		begin
			f         = rand_fields(OP_CEX);
			f.t_count = 3'(take_bits(2));
			f.f_count = 3'(take_bits(2));
			t         = f.t_count + f.f_count + 2;		// Run past the block
			run_instr(f);
			repeat (t) run_instr(rand_fields(OP_MOV));
		end
		test_name = "setpri";
		f     = rand_fields(OP_SETPRI);
		f.pri = 3'd3;		// Below the reset priority
		run_instr(f);
		check_value("psw.pri", 64'(3), 64'(psw.pri));
		f.pri = 3'd3;		// Equal to the current priority
		run_instr(f);
		wait_status(1'b1, 1'b1, "priority fault");
		check_value("vect_num", 64'(VEC_PRI_FAULT), 64'(vect_num));
		idle(8);
		apply_reset();
		test_name = "breakpoint";
		run_instr(rand_fields(OP_MOV));
		pc     = 16'h0040;
		brkpnt = 16'h0040;
		wait_status(1'b0, 1'b1, "halt on breakpoint");
		idle(4);
		check_value("halted", 64'(1), 64'(halted));
		brkpnt = 16'hffff;
		wait_status(1'b0, 1'b0, "release from breakpoint");
		run_instr(rand_fields(OP_SXT));
		test_name = "pc_fault";
		wait_step(FETCH, 1'b1, "FETCH before odd pc");
		pc = 16'h0041;
		wait_status(1'b1, 1'b1, "odd pc fault");
		check_value("vect_num", 64'(VEC_PC_FAULT), 64'(vect_num));
		idle(6);
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if ((errors == 0) && (timeouts == 0))
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
